//--- rtl/frame_rotator.sv
// Frame rotator: double frame buffer with transposed writes and a rotated read raster
module frame_rotator (
	input  logic               clk,
	input  logic               rst,
	input  logic               pix_ce,
	input  video_fx_pkg::pix_t pix,
	input  logic               hbl,
	input  logic               vbl,
	input  logic               ccw,
	output logic               rot_ce,
	output video_fx_pkg::pix_t rot_pix,
	output logic               rot_hs,
	output logic               rot_vs,
	output logic               rot_hbl,
	output logic               rot_vbl
);
	import video_fx_pkg::*;

	pix_t mem [BUF_WORDS];
	pix_t mem_q;

	// Write side
	logic              wr_buf;
	logic              ccw_r;
	logic [BUF_AW-1:0] wr_addr;
	logic [BUF_AW-1:0] row_addr;
	logic              old_blank;
	logic              vbl_d;
	logic              blank;
	logic              we;
	logic              swap;

	// Read side
	rd_state_t         rd_state;
	logic [SLOT_W-1:0] xo;
	logic [LINE_W-1:0] yo;
	logic [7:0]        vbcnt;
	logic [BUF_AW-1:0] rd_addr;
	logic              swap_pend;
	logic              line_end;
	logic              slot_act;
	logic              slot_pic;
	logic              s1_ce;
	logic              s1_pic;
	logic              s1_hbl;
	logic              s1_vbl;
	logic              s1_hs;
	logic              s1_vs;

	// First write address of a frame in the given buffer and direction
	function automatic logic [BUF_AW-1:0] wr_start(input logic buf_sel, input logic dir_ccw);
		logic [BUF_AW-1:0] base;
		base = buf_sel ? BUF_AW'(FRAME_WORDS) : '0;
		return dir_ccw ? base + BUF_AW'(FRAME_WORDS - FRAME_H) : base + BUF_AW'(FRAME_H - 1);
	endfunction

	// ==================================================
	// Write side
	// ==================================================

	assign blank = hbl | vbl;
	assign we    = pix_ce & ~blank;
	assign swap  = pix_ce & vbl & ~vbl_d;

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_addr] <= pix;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_buf    <= 1'b0;
			ccw_r     <= ccw;
			wr_addr   <= wr_start(1'b0, ccw);
			row_addr  <= wr_start(1'b0, ccw);
			old_blank <= 1'b1;
			vbl_d     <= 1'b0;
		end else if (pix_ce) begin
			old_blank <= blank;
			vbl_d     <= vbl;
			if (swap) begin
				// Completed frame becomes the front buffer
				wr_buf   <= ~wr_buf;
				ccw_r    <= ccw;
				wr_addr  <= wr_start(~wr_buf, ccw);
				row_addr <= wr_start(~wr_buf, ccw);
			end else if (blank && !old_blank) begin
				// Next input line is the neighbouring output column
				wr_addr  <= ccw_r ? row_addr + 1'b1 : row_addr - 1'b1;
				row_addr <= ccw_r ? row_addr + 1'b1 : row_addr - 1'b1;
			end else if (we) begin
				wr_addr <= ccw_r ? wr_addr - BUF_AW'(FRAME_H) : wr_addr + BUF_AW'(FRAME_H);
			end
		end
	end

	// ==================================================
	// Read side
	// ==================================================

	assign line_end = (xo == SLOT_W'(LINE_SLOTS - 1));
	assign slot_act = (rd_state == RD_LINES) && (xo < SLOT_W'(FRAME_H));
	// Margin lines keep their active slots but show black
	assign slot_pic = slot_act && (yo >= LINE_W'(MARGIN)) && (yo < LINE_W'(FRAME_W + MARGIN));

	always_ff @(posedge clk) begin
		if (pix_ce) begin
			mem_q <= mem[rd_addr];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state  <= RD_IDLE;
			xo        <= '0;
			yo        <= '0;
			vbcnt     <= '0;
			rd_addr   <= '0;
			swap_pend <= 1'b0;
		end else if (pix_ce) begin
			if (slot_pic) begin
				rd_addr <= rd_addr + 1'b1;
			end
			if (line_end) begin
				xo <= '0;
				if (swap_pend) begin
					// Restart the raster on the frame just completed
					swap_pend <= 1'b0;
					rd_state  <= RD_LINES;
					yo        <= '0;
					vbcnt     <= '0;
					rd_addr   <= wr_buf ? '0 : BUF_AW'(FRAME_WORDS);
				end else begin
					case (rd_state)
						RD_LINES: begin
							if (yo == LINE_W'(ROT_LINES - 1)) begin
								rd_state <= RD_VBLANK;
							end else begin
								yo <= yo + 1'b1;
							end
						end
						RD_VBLANK: begin
							if (vbcnt != 8'hff) begin
								vbcnt <= vbcnt + 1'b1;
							end
						end
						default: ;
					endcase
				end
			end else begin
				xo <= xo + 1'b1;
			end
			if (swap) begin
				swap_pend <= 1'b1;
			end
		end
	end

	// Stage 1: slot flags alongside the memory read
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_ce  <= 1'b0;
			s1_pic <= 1'b0;
			s1_hbl <= 1'b1;
			s1_vbl <= 1'b1;
			s1_hs  <= 1'b0;
			s1_vs  <= 1'b0;
		end else begin
			s1_ce <= pix_ce;
			if (pix_ce) begin
				s1_pic <= slot_pic;
				s1_hbl <= (xo >= SLOT_W'(FRAME_H));
				s1_vbl <= (rd_state != RD_LINES);
				s1_hs  <= (xo >= SLOT_W'(FRAME_H + 8)) && (xo <= SLOT_W'(FRAME_H + 9));
				s1_vs  <= (rd_state == RD_VBLANK) && (vbcnt >= 8'd10) && (vbcnt <= 8'd11);
			end
		end
	end

	// Stage 2: blank and margin masking
	always_ff @(posedge clk) begin
		if (s1_ce) begin
			rot_pix <= s1_pic ? mem_q : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rot_ce  <= 1'b0;
			rot_hbl <= 1'b1;
			rot_vbl <= 1'b1;
			rot_hs  <= 1'b0;
			rot_vs  <= 1'b0;
		end else begin
			rot_ce <= s1_ce;
			if (s1_ce) begin
				rot_hbl <= s1_hbl;
				rot_vbl <= s1_vbl;
				rot_hs  <= s1_hs;
				rot_vs  <= s1_vs;
			end
		end
	end

endmodule

//--- rtl/output_select.sv
// Output select: direct or rotated stream, 3-3-2 to 8-8-8 expansion, registered video port
module output_select (
	input  logic                clk,
	input  logic                rst,
	input  logic                rotate_en,
	input  logic                pix_ce,
	input  video_fx_pkg::pix_t  pix,
	input  logic                hbl,
	input  logic                vbl,
	input  logic                rot_ce,
	input  video_fx_pkg::pix_t  rot_pix,
	input  logic                rot_hbl,
	input  logic                rot_vbl,
	input  logic                rot_hs,
	input  logic                rot_vs,
	output logic                out_ce,
	output video_fx_pkg::chan_t r,
	output video_fx_pkg::chan_t g,
	output video_fx_pkg::chan_t b,
	output logic                hs,
	output logic                vs,
	output logic                de
);
	import video_fx_pkg::*;

	logic rot_sel;
	logic hbl_d;
	logic vbl_d;
	logic dir_hs;
	logic dir_vs;
	logic sel_ce;
	pix_t sel_pix;
	logic sel_de;
	logic sel_hs;
	logic sel_vs;

	// The input has no sync pins, so syncs start at the blank edges
	assign dir_hs = hbl & ~hbl_d;
	assign dir_vs = vbl & ~vbl_d;

	assign sel_ce  = rot_sel ? rot_ce : pix_ce;
	assign sel_pix = rot_sel ? rot_pix : pix;
	assign sel_de  = rot_sel ? ~(rot_hbl | rot_vbl) : ~(hbl | vbl);
	assign sel_hs  = rot_sel ? rot_hs : dir_hs;
	assign sel_vs  = rot_sel ? rot_vs : dir_vs;

	// Mode only changes at the start of input vertical blank
	always_ff @(posedge clk) begin
		if (rst) begin
			rot_sel <= rotate_en;
			hbl_d   <= 1'b0;
			vbl_d   <= 1'b0;
		end else if (pix_ce) begin
			hbl_d <= hbl;
			vbl_d <= vbl;
			if (dir_vs) begin
				rot_sel <= rotate_en;
			end
		end
	end

	// ==================================================
	// Output port
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			out_ce <= 1'b0;
			de     <= 1'b0;
			hs     <= 1'b0;
			vs     <= 1'b0;
			r      <= '0;
			g      <= '0;
			b      <= '0;
		end else begin
			out_ce <= sel_ce;
			if (sel_ce) begin
				de <= sel_de;
				hs <= sel_hs;
				vs <= sel_vs;
				// Bit repeat keeps full black and full white exact
				r  <= sel_de ? {sel_pix[7:5], sel_pix[7:5], sel_pix[7:6]} : '0;
				g  <= sel_de ? {sel_pix[4:2], sel_pix[4:2], sel_pix[4:3]} : '0;
				b  <= sel_de ? {4{sel_pix[1:0]}} : '0;
			end
		end
	end

endmodule

//--- rtl/pixel_capture.sv
// Pixel capture: pixel enable edge detect, pixel and blanking registers, line-aligned vblank
module pixel_capture (
	input  logic               clk,
	input  logic               rst,
	input  logic               ce_pix,
	input  video_fx_pkg::pix_t rgb_in,
	input  logic               hblank_in,
	input  logic               vblank_in,
	output logic               pix_ce,
	output video_fx_pkg::pix_t pix,
	output logic               hbl,
	output logic               vbl
);

	logic ce_d;
	logic ce_rise;

	// One pixel per rising edge of the enable, however long it stays high
	assign ce_rise = ce_pix & ~ce_d;

	always_ff @(posedge clk) begin
		if (rst) begin
			ce_d   <= 1'b0;
			pix_ce <= 1'b0;
		end else begin
			ce_d   <= ce_pix;
			pix_ce <= ce_rise;
		end
	end

	// Pixel payload
	always_ff @(posedge clk) begin
		if (ce_rise) begin
			pix <= rgb_in;
		end
	end

	// Blanking flags
	always_ff @(posedge clk) begin
		if (rst) begin
			hbl <= 1'b0;
			vbl <= 1'b0;
		end else if (ce_rise) begin
			hbl <= hblank_in;
			// Vertical blank only moves at the end of horizontal blank,
			// so it always changes on a line boundary
			if (hbl && !hblank_in) begin
				vbl <= vblank_in;
			end
		end
	end

endmodule

//--- rtl/video_fx.sv
// Video effect top level: capture, frame rotator and output select
module video_fx (
	input  logic                clk,
	input  logic                rst,
	input  logic                ce_pix,
	input  video_fx_pkg::pix_t  rgb_in,
	input  logic                hblank_in,
	input  logic                vblank_in,
	input  logic                rotate_en,
	input  logic                ccw,
	output logic                out_ce,
	output video_fx_pkg::chan_t r,
	output video_fx_pkg::chan_t g,
	output video_fx_pkg::chan_t b,
	output logic                hs,
	output logic                vs,
	output logic                de
);
	import video_fx_pkg::*;

	// Captured stream
	logic pix_ce;
	pix_t pix;
	logic hbl;
	logic vbl;

	// Rotated stream
	logic rot_ce;
	pix_t rot_pix;
	logic rot_hs;
	logic rot_vs;
	logic rot_hbl;
	logic rot_vbl;

	pixel_capture capture_i (
		.clk       (clk),
		.rst       (rst),
		.ce_pix    (ce_pix),
		.rgb_in    (rgb_in),
		.hblank_in (hblank_in),
		.vblank_in (vblank_in),
		.pix_ce    (pix_ce),
		.pix       (pix),
		.hbl       (hbl),
		.vbl       (vbl)
	);

	frame_rotator rotator_i (
		.clk     (clk),
		.rst     (rst),
		.pix_ce  (pix_ce),
		.pix     (pix),
		.hbl     (hbl),
		.vbl     (vbl),
		.ccw     (ccw),
		.rot_ce  (rot_ce),
		.rot_pix (rot_pix),
		.rot_hs  (rot_hs),
		.rot_vs  (rot_vs),
		.rot_hbl (rot_hbl),
		.rot_vbl (rot_vbl)
	);

	output_select select_i (
		.clk       (clk),
		.rst       (rst),
		.rotate_en (rotate_en),
		.pix_ce    (pix_ce),
		.pix       (pix),
		.hbl       (hbl),
		.vbl       (vbl),
		.rot_ce    (rot_ce),
		.rot_pix   (rot_pix),
		.rot_hbl   (rot_hbl),
		.rot_vbl   (rot_vbl),
		.rot_hs    (rot_hs),
		.rot_vs    (rot_vs),
		.out_ce    (out_ce),
		.r         (r),
		.g         (g),
		.b         (b),
		.hs        (hs),
		.vs        (vs),
		.de        (de)
	);

endmodule

//--- rtl/video_fx_pkg.sv
// Video effect package: pixel and channel types, frame geometry, buffer sizes, read FSM states
package video_fx_pkg;

	// ==================================================
	// Pixel types
	// ==================================================

	// 3-3-2 input pixel: red [7:5], green [4:2], blue [1:0]
	typedef logic [7:0] pix_t;

	// One expanded output channel
	typedef logic [7:0] chan_t;

	// ==================================================
	// Frame geometry
	// ==================================================

	localparam int FRAME_W = 16;
	localparam int FRAME_H = 8;

	// Black lines above and below the rotated picture
	localparam int MARGIN = 2;

	// Rotated raster: FRAME_H active slots plus horizontal blank
	localparam int LINE_SLOTS = FRAME_H + 18;
	localparam int ROT_LINES  = FRAME_W + 2 * MARGIN;
	localparam int SLOT_W     = $clog2(LINE_SLOTS);
	localparam int LINE_W     = $clog2(ROT_LINES);

	// ==================================================
	// Frame buffer
	// ==================================================

	localparam int FRAME_WORDS = FRAME_W * FRAME_H;
	localparam int BUF_WORDS   = 2 * FRAME_WORDS;
	localparam int BUF_AW      = $clog2(BUF_WORDS);

	// Rotator read raster
	typedef enum logic [1:0] {
		RD_IDLE,
		RD_LINES,
		RD_VBLANK
	} rd_state_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the video effect simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module video_fx_tb -f video_fx.f -o sim_video_fx

out=$(./obj_dir/sim_video_fx 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^TEST PASS$"; then
	exit 0
else
	exit 1
fi

//--- tb/clk_gen.sv
// Testbench clock source with an 8 ns period
module clk_gen (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
	end

	always #4 clk = ~clk;

endmodule

//--- tb/video_fx_sva.sv
// Output port protocol assertions, bound into the video effect top level
module video_fx_sva (
	input logic       clk,
	input logic       rst,
	input logic       out_ce,
	input logic       de,
	input logic       hs,
	input logic       vs,
	input logic [7:0] r,
	input logic [7:0] g,
	input logic [7:0] b
);
	timeunit 1ns;
	timeprecision 100ps;

	// Port stays quiet through reset
	a_quiet_in_reset: assert property (@(posedge clk)
		(rst && $past(rst)) |-> !(de || out_ce || hs || vs))
		else $error("output port active during reset");

	// One output pixel per strobe
	a_ce_single: assert property (@(posedge clk) disable iff (rst)
		out_ce |=> !out_ce)
		else $error("out_ce high on two consecutive clocks");

	// Colours are black outside the display area
	a_black_blank: assert property (@(posedge clk)
		!de |-> (r == 8'd0 && g == 8'd0 && b == 8'd0))
		else $error("nonzero colour while de is low");

endmodule

bind video_fx video_fx_sva video_fx_sva_i (
	.clk    (clk),
	.rst    (rst),
	.out_ce (out_ce),
	.de     (de),
	.hs     (hs),
	.vs     (vs),
	.r      (r),
	.g      (g),
	.b      (b)
);

//--- tb/video_fx_tb.sv
// Video effect testbench with LFSR pixel source, frame model, output monitor and checks
module video_fx_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int IN_W         = 16;
	localparam int IN_H         = 8;
	localparam int MARGIN_LINES = 2;
	localparam int HBL_SLOTS    = 6;
	localparam int VBL_LINES    = 40;
	localparam int NUM_FRAMES   = 8;
	localparam int EXP_FRAMES   = 9;
	localparam int TIMEOUT      = 20000;

	logic       clk;
	logic       rst;
	logic       ce_pix;
	logic [7:0] rgb_in;
	logic       hblank_in;
	logic       vblank_in;
	logic       rotate_en;
	logic       ccw;
	logic       out_ce;
	logic [7:0] r;
	logic [7:0] g;
	logic [7:0] b;
	logic       hs;
	logic       vs;
	logic       de;

	logic [31:0] lfsr;
	logic [7:0]  model [NUM_FRAMES][IN_H][IN_W];
	logic        ccw_frame [NUM_FRAMES];

	// Mode changes applied in the middle of each frame
	logic rot_mid [NUM_FRAMES] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
	logic ccw_mid [NUM_FRAMES] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};

	// Expected output frames with the oldest first
	bit exp_rot [$];
	int exp_idx [$];
	bit exp_ccw [$];

	// Monitor state
	int   pos;
	int   hs_cnt;
	int   frames_done;
	logic hs_q;
	logic vs_q;

	clk_gen clk_gen_i (
		.clk (clk)
	);

	video_fx video_fx_i (
		.clk       (clk),
		.rst       (rst),
		.ce_pix    (ce_pix),
		.rgb_in    (rgb_in),
		.hblank_in (hblank_in),
		.vblank_in (vblank_in),
		.rotate_en (rotate_en),
		.ccw       (ccw),
		.out_ce    (out_ce),
		.r         (r),
		.g         (g),
		.b         (b),
		.hs        (hs),
		.vs        (vs),
		.de        (de)
	);

	// ==================================================
	// Helpers
	// ==================================================

	task automatic report_mismatch(input string what);
		$display("error: time %0t ns: %s", $time, what);
		$display("TEST FAIL");
		$fatal(1, "output check failed");
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out: %s", what);
		$display("TEST FAIL");
		$fatal(1, "timeout");
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic next_pixel(output logic [7:0] p);
		p = 8'd0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			p = {p[6:0], lfsr[0]};
		end
	endtask

	// Fill 8 bits by repeating an n-bit channel from its MSB
	function automatic logic [7:0] repeat_bits(input logic [2:0] v, input int n);
		logic [7:0] res;
		for (int i = 0; i < 8; i++) begin
			res[7 - i] = v[n - 1 - (i % n)];
		end
		return res;
	endfunction

	function automatic logic [23:0] expected_rgb(input bit is_rot, input int idx,
			input bit dir_ccw, input int line, input int col);
		logic [7:0] p;
		int row;
		row = line - MARGIN_LINES;
		if (!is_rot) begin
			p = model[idx][line][col];
		end else if (line < MARGIN_LINES || line >= IN_W + MARGIN_LINES) begin
			return 24'd0;
		end else if (dir_ccw) begin
			p = model[idx][col][IN_W - 1 - row];
		end else begin
			p = model[idx][IN_H - 1 - col][row];
		end
		return {repeat_bits(p[7:5], 3), repeat_bits(p[4:2], 3),
			repeat_bits({1'b0, p[1:0]}, 2)};
	endfunction

	// ==================================================
	// Stimulus
	// ==================================================

	// One pixel slot with the enable high for one clock in four
	task automatic send_slot(input logic [7:0] p, input logic hb, input logic vb);
		@(posedge clk);
		#1;
		ce_pix    = 1'b1;
		rgb_in    = p;
		hblank_in = hb;
		vblank_in = vb;
		repeat (3) begin
			@(posedge clk);
			#1;
			ce_pix = 1'b0;
		end
	endtask

	task automatic send_frame(input int n);
		logic [7:0] p;
		logic       hb;
		for (int line = 0; line < IN_H + VBL_LINES; line++) begin
			if (line == IN_H / 2) begin
				rotate_en = rot_mid[n];
				ccw       = ccw_mid[n];
			end
			if (line == IN_H) begin
				// Mode and direction are taken at the start of vertical blank
				if (rotate_en) begin
					exp_rot.push_back(1'b1);
					exp_idx.push_back(n);
					exp_ccw.push_back(ccw_frame[n]);
				end else if (n + 1 < NUM_FRAMES) begin
					exp_rot.push_back(1'b0);
					exp_idx.push_back(n + 1);
					exp_ccw.push_back(1'b0);
				end
				if (n + 1 < NUM_FRAMES) begin
					ccw_frame[n + 1] = ccw;
				end
			end
			for (int slot = 0; slot < IN_W + HBL_SLOTS; slot++) begin
				hb = (slot >= IN_W);
				if (line < IN_H && !hb) begin
					next_pixel(p);
					model[n][line][slot] = p;
				end else begin
					p = 8'hff;
				end
				send_slot(p, hb, line >= IN_H);
			end
		end
	endtask

	initial begin
		int wait_cnt;
		lfsr      = 32'h8925;
		rst       = 1'b1;
		ce_pix    = 1'b0;
		rgb_in    = 8'd0;
		hblank_in = 1'b0;
		vblank_in = 1'b0;
		rotate_en = 1'b0;
		ccw       = 1'b0;
		ccw_frame[0] = 1'b0;
		exp_rot.push_back(1'b0);
		exp_idx.push_back(0);
		exp_ccw.push_back(1'b0);
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int n = 0; n < NUM_FRAMES; n++) begin
			send_frame(n);
		end
		wait_cnt = 0;
		while (exp_rot.size() != 0 && wait_cnt < TIMEOUT) begin
			@(posedge clk);
			wait_cnt++;
		end
		if (exp_rot.size() != 0) begin
			report_timeout("expected output frames never completed");
		end
		if (frames_done == EXP_FRAMES) begin
			$display("TEST PASS");
			$finish;
		end else begin
			report_mismatch($sformatf("%0d vs pulses for %0d output frames",
				frames_done, EXP_FRAMES));
		end
	end

	// ==================================================
	// Output monitor
	// ==================================================

	task automatic close_frame();
		int total;
		if (pos > 0) begin
			total = exp_rot[0] ? IN_H * (IN_W + 2 * MARGIN_LINES) : IN_W * IN_H;
			assert (pos == total)
				else report_mismatch($sformatf("frame ended after %0d of %0d pixels", pos, total));
			void'(exp_rot.pop_front());
			void'(exp_idx.pop_front());
			void'(exp_ccw.pop_front());
		end
		pos    = 0;
		hs_cnt = 0;
	endtask

	task automatic take_pixel();
		int len;
		int nlines;
		int line;
		int col;
		logic [23:0] expv;
		assert (exp_rot.size() != 0)
			else report_mismatch("output pixel with no frame expected");
		len    = exp_rot[0] ? IN_H : IN_W;
		nlines = exp_rot[0] ? IN_W + 2 * MARGIN_LINES : IN_H;
		line   = pos / len;
		col    = pos % len;
		assert (pos < len * nlines)
			else report_mismatch("more display pixels than a frame holds");
		if (pos > 0) begin
			assert (hs_cnt == ((col == 0) ? 1 : 0))
				else report_mismatch($sformatf("%0d hs pulses before line %0d col %0d",
					hs_cnt, line, col));
		end
		expv = expected_rgb(exp_rot[0], exp_idx[0], exp_ccw[0], line, col);
		assert ({r, g, b} == expv)
			else report_mismatch($sformatf("frame %0d line %0d col %0d got %06h expected %06h",
				exp_idx[0], line, col, {r, g, b}, expv));
		hs_cnt = 0;
		pos++;
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (rst) begin
			pos         = 0;
			hs_cnt      = 0;
			frames_done = 0;
			hs_q        = 1'b0;
			vs_q        = 1'b0;
		end else begin
			if (hs && !hs_q) begin
				hs_cnt++;
			end
			// Each vs rise ends one output frame
			if (vs && !vs_q) begin
				frames_done++;
				close_frame();
			end
			if (out_ce && de) begin
				take_pixel();
			end
			hs_q = hs;
			vs_q = vs;
		end
	end

endmodule

//--- video_fx.f
rtl/video_fx_pkg.sv
rtl/pixel_capture.sv
rtl/frame_rotator.sv
rtl/output_select.sv
rtl/video_fx.sv
tb/clk_gen.sv
tb/video_fx_sva.sv
tb/video_fx_tb.sv
